// ==== design/data_port.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module data_port import mem_port_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  data_req_t     req,
    output array_access_t acc,
    input  data_rsp_t     rd,
    output data_rsp_t     rsp,
    output logic          ready,
    output logic          ack
);
    localparam int CNT_BITS = $clog2(`MEM_LATENCY);

    port_state_t         state;
    logic [CNT_BITS-1:0] count;
    logic                any_req;
    logic                start;

    assign ready   = (state == port_idle);
    assign any_req = req.read || req.write_word || req.write_quad;
    assign start   = any_req && ready;

    // write bits reach the array only on the accept cycle.
    // A read masks both writes, and a word write masks a quad write.
    always_comb begin
        acc            = '0;
        acc.accept     = start;
        acc.addr       = req.addr;
        acc.write_word = start && !req.read && req.write_word;
        acc.write_quad = start && !req.read && !req.write_word && req.write_quad;
        acc.wdata      = req.wdata;
        acc.wquad      = req.wquad;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= port_idle;
            count <= '0;
            ack   <= 1'b0;
        end else begin
            case (state)
                port_idle: begin
                    if (start) begin
                        state <= port_busy;
                        count <= CNT_BITS'(`MEM_LATENCY - 1);
                    end
                end
                port_busy: begin
                    if (ack) begin
                        state <= port_idle;   // ready returns on the cycle after ack.
                        ack   <= 1'b0;
                    end else if (count == '0) begin
                        ack <= 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= port_idle;
            endcase
        end
    end

    // the response keeps the last read, so a write leaves it unchanged.
    always_ff @(posedge clk) begin
        if (start && req.read) begin
            rsp <= rd;
        end
    end

    a_data_one_kind: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({req.read, req.write_word, req.write_quad}))
        else $error("data request sets more than one access kind.");

    a_data_req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (state == port_busy) |-> $stable(req))
        else $error("data request changed before its acknowledge.");

endmodule

// ==== design/dual_port_memory.sv ====
`timescale 1ns/1ns

module dual_port_memory import mem_port_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  fetch_req_t fetch_req,
    output fetch_rsp_t fetch_rsp,
    output logic       fetch_ready,
    output logic       fetch_ack,
    input  data_req_t  data_req,
    output data_rsp_t  data_rsp,
    output logic       data_ready,
    output logic       data_ack
);
    array_access_t fetch_acc;
    array_access_t data_acc;
    fetch_rsp_t    fetch_rd;
    data_rsp_t     data_rd;

    fetch_port u_fetch_port (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (fetch_req),
        .acc     (fetch_acc),
        .rd      (fetch_rd),
        .rsp     (fetch_rsp),
        .ready   (fetch_ready),
        .ack     (fetch_ack)
    );

    data_port u_data_port (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (data_req),
        .acc     (data_acc),
        .rd      (data_rd),
        .rsp     (data_rsp),
        .ready   (data_ready),
        .ack     (data_ack)
    );

    mem_array u_mem_array (
        .clk       (clk),
        .reset_n   (reset_n),
        .fetch_acc (fetch_acc),
        .data_acc  (data_acc),
        .fetch_rd  (fetch_rd),
        .data_rd   (data_rd)
    );

endmodule

// ==== design/fetch_port.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module fetch_port import mem_port_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  fetch_req_t    req,
    output array_access_t acc,
    input  fetch_rsp_t    rd,
    output fetch_rsp_t    rsp,
    output logic          ready,
    output logic          ack
);
    localparam int CNT_BITS = $clog2(`MEM_LATENCY);

    port_state_t         state;
    logic [CNT_BITS-1:0] count;
    logic                start;

    assign ready = (state == port_idle);
    assign start = req.read && ready;

    // the fetch side never writes, so the write fields stay zero.
    always_comb begin
        acc        = '0;
        acc.accept = start;
        acc.addr   = req.addr;
    end

    // the counter runs down to zero, then ack is raised for one cycle
    // and the port returns to idle on the edge after it.
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= port_idle;
            count <= '0;
            ack   <= 1'b0;
        end else begin
            case (state)
                port_idle: begin
                    if (start) begin
                        state <= port_busy;
                        count <= CNT_BITS'(`MEM_LATENCY - 1);
                    end
                end
                port_busy: begin
                    if (ack) begin
                        state <= port_idle;
                        ack   <= 1'b0;
                    end else if (count == '0) begin
                        ack <= 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= port_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rsp <= rd;   // read data is taken on the accept edge.
        end
    end

    a_fetch_req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (state == port_busy) |-> $stable(req))
        else $error("fetch request changed before its acknowledge.");

endmodule

// ==== design/mem_array.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_array import mem_width_pkg::*, mem_port_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  array_access_t fetch_acc,
    input  array_access_t data_acc,
    output fetch_rsp_t    fetch_rd,
    output data_rsp_t     data_rd
);
    localparam int AW = `MEM_ADDR_BITS;
    localparam int WW = $bits(word_t);

    typedef logic [AW-1:0] index_t;

    word_t  mem [`MEM_DEPTH];
    index_t fetch_idx;
    index_t data_idx;
    qword_t fetch_quad;
    qword_t data_quad;
    logic   fwd_hit;

    // short boot program. Every word not listed is zero.
    function automatic word_t boot_word(input index_t idx);
        case (idx)
            'h00: return 16'h9023;
            'h01: return 16'h0001;
            'h02: return 16'hffff;
            'h23: return 16'h6000;
            'h24: return 16'hf01c;
            'h25: return 16'h6100;
            'h26: return 16'hf41c;
            'h27: return 16'h6200;
            'h28: return 16'hf81c;
            'h29: return 16'h6300;
            'h2a: return 16'hfc1c;
            default: return '0;
        endcase
    endfunction

    assign fetch_idx = fetch_acc.addr[AW-1:0];
    assign data_idx  = data_acc.addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                mem[i] <= boot_word(index_t'(i));
            end
        end else if (data_acc.accept) begin
            if (data_acc.write_word) begin
                mem[data_idx] <= data_acc.wdata;
            end else if (data_acc.write_quad) begin
                for (int k = 0; k < 4; k++) begin
                    mem[data_idx + index_t'(k)] <= data_acc.wquad[k*WW +: WW];
                end
            end
        end
    end

    // quad reads wrap at the top of the array since the index is only AW bits wide.
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            fetch_quad[k*WW +: WW] = mem[fetch_idx + index_t'(k)];
            data_quad[k*WW +: WW]  = mem[data_idx + index_t'(k)];
        end
    end

    assign fwd_hit = fetch_acc.accept && data_acc.accept && (fetch_idx == data_idx)
                     && (data_acc.write_word || data_acc.write_quad);

    // a fetch in the same cycle as a write to its address sees the new data.
    // The word field is forwarded for both write kinds.
    always_comb begin
        fetch_rd.word = fetch_quad[WW-1:0];
        fetch_rd.quad = fetch_quad;
        if (fwd_hit) begin
            fetch_rd.word = data_acc.wdata;
            if (data_acc.write_quad) begin
                fetch_rd.quad = data_acc.wquad;
            end else begin
                fetch_rd.quad[WW-1:0] = data_acc.wdata;   // upper words stay as stored.
            end
        end
    end

    assign data_rd.word = data_quad[WW-1:0];
    assign data_rd.quad = data_quad;

    a_fetch_no_write: assert property (@(posedge clk) disable iff (!reset_n)
        !(fetch_acc.write_word || fetch_acc.write_quad))
        else $error("fetch access carries a write strobe.");

endmodule

// ==== design/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// storage depth in 16-bit words.
`define MEM_DEPTH 256

// number of low address bits the array decodes.
// Higher address bits are ignored, so accesses wrap modulo the depth.
`define MEM_ADDR_BITS 8

// clock edges from the accept edge to the acknowledge edge.
// The port counters need a value of at least 2.
`define MEM_LATENCY 6

`endif

// ==== design/mem_port_pkg.sv ====
package mem_port_pkg;
    import mem_width_pkg::*;

    typedef enum logic {
        port_idle,
        port_busy
    } port_state_t;

    typedef struct packed {
        logic  read;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        word_t  word;
        qword_t quad;
    } fetch_rsp_t;

    typedef struct packed {
        logic   read;        // read has priority over the write bits.
        logic   write_word;
        logic   write_quad;
        addr_t  addr;
        word_t  wdata;
        qword_t wquad;
    } data_req_t;

    typedef struct packed {
        word_t  word;
        qword_t quad;
    } data_rsp_t;

    // strobe from a port sequencer to the array, high for the accept cycle only.
    typedef struct packed {
        logic   accept;
        addr_t  addr;
        logic   write_word;
        logic   write_quad;
        word_t  wdata;
        qword_t wquad;
    } array_access_t;

endpackage

// ==== design/mem_width_pkg.sv ====
package mem_width_pkg;

    // one memory word.
    typedef logic [15:0] word_t;

    // four consecutive words with the lowest address in the low bits.
    typedef logic [4*$bits(word_t)-1:0] qword_t;

    // full processor address. Only the low bits reach the storage.
    typedef logic [15:0] addr_t;

endpackage

// ==== tb.f ====
+incdir+design
design/mem_width_pkg.sv
design/mem_port_pkg.sv
design/fetch_port.sv
design/data_port.sv
design/mem_array.sv
design/dual_port_memory.sv
tests/tb_dual_port_memory.sv

// ==== tests/tb_dual_port_memory.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module tb_dual_port_memory import mem_width_pkg::*, mem_port_pkg::*;;
    localparam int N_DIRECTED  = 22;
    localparam int N_RANDOM    = 40;
    localparam int CYCLE_LIMIT = (N_DIRECTED + N_RANDOM + 40) * (`MEM_LATENCY + 2);

    typedef enum logic [1:0] {op_read, op_write_word, op_write_quad} op_kind_t;

    typedef struct packed {
        logic     port;       // 0 is the fetch port, 1 is the data port.
        op_kind_t kind;
        addr_t    addr;
        qword_t   data;       // wquad, and wdata is its low word.
        logic     together;   // issued in the same cycle as the next entry.
    } op_t;

    logic       clk;
    logic       reset_n;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    logic       fetch_ready;
    logic       fetch_ack;
    data_req_t  data_req;
    data_rsp_t  data_rsp;
    logic       data_ready;
    logic       data_ack;

    word_t model [`MEM_DEPTH];
    op_t   ops [$];
    int    cycles = 0;

    dual_port_memory dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .fetch_req   (fetch_req),
        .fetch_rsp   (fetch_rsp),
        .fetch_ready (fetch_ready),
        .fetch_ack   (fetch_ack),
        .data_req    (data_req),
        .data_rsp    (data_rsp),
        .data_ready  (data_ready),
        .data_ack    (data_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_run("The run took too many cycles and was stopped by the timeout.");
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("[ERROR] %0t: %s", $time, msg));
    endtask

    task automatic init_model();
        foreach (model[i]) model[i] = 16'h0000;
        model['h00] = 16'h9023;
        model['h01] = 16'h0001;
        model['h02] = 16'hffff;
        model['h23] = 16'h6000;
        model['h24] = 16'hf01c;
        model['h25] = 16'h6100;
        model['h26] = 16'hf41c;
        model['h27] = 16'h6200;
        model['h28] = 16'hf81c;
        model['h29] = 16'h6300;
        model['h2a] = 16'hfc1c;
    endtask

    function automatic int wrap_index(input addr_t a, input int k);
        return (int'(a) + k) % `MEM_DEPTH;   // high address bits drop out here.
    endfunction

    function automatic qword_t model_quad(input addr_t a);
        qword_t q;
        for (int k = 0; k < 4; k++) q[16*k +: 16] = model[wrap_index(a, k)];
        return q;
    endfunction

    task automatic model_write(input op_t op);
        if (op.kind == op_write_word) begin
            model[wrap_index(op.addr, 0)] = op.data[15:0];
        end else if (op.kind == op_write_quad) begin
            for (int k = 0; k < 4; k++) model[wrap_index(op.addr, k)] = op.data[16*k +: 16];
        end
    endtask

    // a fetch accepted with a data write to its address sees the write data.
    task automatic apply_forward(input op_t rd, input op_t wr, inout word_t w, inout qword_t q);
        if (!rd.port && rd.kind == op_read && wr.port && wr.kind != op_read
                && wrap_index(rd.addr, 0) == wrap_index(wr.addr, 0)) begin
            w = wr.data[15:0];
            if (wr.kind == op_write_quad) q = wr.data;
            else q[15:0] = wr.data[15:0];
        end
    endtask

    task automatic add_op(input logic port, input op_kind_t kind, input addr_t addr,
                          input qword_t data, input logic together);
        ops.push_back('{port, kind, addr, data, together});
    endtask

    task automatic build_table();
        logic     port;
        op_kind_t kind;
        addr_t    a;
        add_op(0, op_read, 16'h0000, '0, 0);
        add_op(0, op_read, 16'h0002, '0, 0);
        add_op(0, op_read, 16'h0023, '0, 0);
        add_op(0, op_read, 16'h0027, '0, 0);
        add_op(1, op_write_word, 16'h0040, 64'h1234, 0);
        add_op(0, op_read, 16'h0040, '0, 0);
        add_op(1, op_read, 16'h0040, '0, 0);
        add_op(1, op_write_quad, 16'h0050, 64'h4444_3333_2222_1111, 0);
        add_op(0, op_read, 16'h0050, '0, 0);
        add_op(1, op_read, 16'h0052, '0, 0);
        add_op(1, op_write_quad, 16'h00fe, 64'hdddd_cccc_bbbb_aaaa, 0);
        add_op(0, op_read, 16'h00fe, '0, 0);
        add_op(1, op_read, 16'h1200, '0, 0);
        add_op(1, op_read, 16'h00ff, '0, 0);
        add_op(0, op_read, 16'h0060, '0, 1);
        add_op(1, op_write_word, 16'h0060, 64'hbeef, 0);
        add_op(1, op_write_quad, 16'h0070, 64'h8888_7777_6666_5555, 1);
        add_op(0, op_read, 16'h0070, '0, 0);
        add_op(0, op_read, 16'h0023, '0, 1);
        add_op(1, op_write_quad, 16'h0024, 64'hcafe_babe_f00d_d00d, 0);
        add_op(1, op_read, 16'h0050, '0, 1);
        add_op(0, op_read, 16'h0040, '0, 0);
        for (int n = 0; n < N_RANDOM; n++) begin
            port = 1'($urandom);
            kind = port ? op_kind_t'($urandom % 3) : op_read;
            a    = {8'($urandom), 4'h8, 4'($urandom)};   // small window so reads hit writes.
            add_op(port, kind, a, {$urandom, $urandom}, 0);
        end
        for (int i = N_DIRECTED; i + 1 < ops.size(); i++) begin
            if (ops[i].port != ops[i + 1].port && $urandom % 2 == 1) begin
                ops[i].together = 1'b1;
                i++;
            end
        end
    endtask

    function automatic logic port_ready(input logic p);
        return p ? data_ready : fetch_ready;
    endfunction

    function automatic logic port_ack(input logic p);
        return p ? data_ack : fetch_ack;
    endfunction

    task automatic drive_request(input op_t op);
        if (!op.port) begin
            fetch_req.read = 1'b1;
            fetch_req.addr = op.addr;
        end else begin
            data_req            = '0;
            data_req.read       = (op.kind == op_read);
            data_req.write_word = (op.kind == op_write_word);
            data_req.write_quad = (op.kind == op_write_quad);
            data_req.addr       = op.addr;
            data_req.wdata      = op.data[15:0];
            data_req.wquad      = op.data;
        end
    endtask

    // runs one access from a point 1 ns after an edge to 1 ns after the edge past ack.
    task automatic do_access(input op_t op, input word_t ew, input qword_t eq, input bit keep);
        int     edges;
        word_t  got_w;
        qword_t got_q;
        drive_request(op);
        while (!port_ready(op.port)) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);   // accept edge.
        #1;
        edges = 0;
        while (!port_ack(op.port) && edges <= `MEM_LATENCY) begin
            assert (!port_ready(op.port))
                else report_mismatch($sformatf("port %0d ready high while busy", op.port));
            @(posedge clk);
            #1;
            edges++;
        end
        assert (edges == `MEM_LATENCY && !port_ready(op.port))
            else report_mismatch($sformatf("port %0d ack after %0d edges, expected %0d",
                                           op.port, edges, `MEM_LATENCY));
        if (op.kind == op_read) begin
            got_w = op.port ? data_rsp.word : fetch_rsp.word;
            got_q = op.port ? data_rsp.quad : fetch_rsp.quad;
            assert (got_w === ew)
                else report_mismatch($sformatf("port %0d word at %h is %h, expected %h",
                                               op.port, op.addr, got_w, ew));
            assert (got_q === eq)
                else report_mismatch($sformatf("port %0d quad at %h is %h, expected %h",
                                               op.port, op.addr, got_q, eq));
        end
        @(posedge clk);
        #1;
        assert (!port_ack(op.port) && port_ready(op.port))
            else report_mismatch($sformatf("port %0d ack too long or ready still low", op.port));
        if (!keep) begin
            if (!op.port) fetch_req = '0;
            else data_req = '0;
        end
    endtask

    task automatic run_group(input op_t a, input op_t b, input bit paired);
        word_t  w [2];
        qword_t q [2];
        w[0] = model[wrap_index(a.addr, 0)];   // reads see memory from before the edge.
        q[0] = model_quad(a.addr);
        w[1] = model[wrap_index(b.addr, 0)];
        q[1] = model_quad(b.addr);
        if (paired) begin
            apply_forward(a, b, w[0], q[0]);
            apply_forward(b, a, w[1], q[1]);
        end
        model_write(a);
        if (paired) begin
            model_write(b);
            fork
                do_access(a, w[0], q[0], 0);
                do_access(b, w[1], q[1], 0);
            join
        end else begin
            do_access(a, w[0], q[0], 0);
        end
    endtask

    initial begin
        op_t hold_op;
        int  i;
        void'($urandom(32'he5625bcf));
        reset_n   = 1'b0;
        fetch_req = '0;
        data_req  = '0;
        init_model();
        build_table();
        repeat (8) @(posedge clk);
        #1 reset_n = 1'b1;
        assert (fetch_ready && data_ready && !fetch_ack && !data_ack)
            else report_mismatch("ready or ack wrong after reset");

        // the request is held past ack, and may only be taken again once ready is back.
        hold_op = '{1'b0, op_read, 16'h0001, 64'h0, 1'b0};
        do_access(hold_op, model[1], model_quad(16'h0001), 1);
        do_access(hold_op, model[1], model_quad(16'h0001), 0);

        i = 0;
        while (i < ops.size()) begin
            if (ops[i].together) begin
                run_group(ops[i], ops[i + 1], 1);
                i += 2;
            end else begin
                run_group(ops[i], ops[i], 0);
                i++;
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule
